//--- verilog/hough_geometry_pkg.sv
package hough_geometry_pkg;

    //////////////////////////////////////////////////
    // angle and fixed-point constants
    //////////////////////////////////////////////////

    // angle index t stands for pi*t/THETAS.
    localparam int THETAS     = 16;
    localparam int THETA_BITS = 4;

    // trig entries are signed bytes scaled by 2**TRIG_FRAC.
    localparam int TRIG_BITS = 8;
    localparam int TRIG_FRAC = 6;
    localparam int TRIG_ONE  = 1 << TRIG_FRAC;

    // one rho bin spans two pixels.
    localparam int RHO_SHIFT = 7;
    localparam int VOTE_BITS = 8;

    // cos in the upper byte, sin in the lower byte.
    localparam string TRIG_FILE = "verilog/trig_table.hex";

    //////////////////////////////////////////////////
    // bin geometry
    //////////////////////////////////////////////////

    function automatic int coord_bits(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // lifts the most negative x*cos term to zero.
    function automatic int rho_offset(int width);
        return (width - 1) * TRIG_ONE;
    endfunction

    // each trig term is at most TRIG_ONE.
    function automatic int rho_sum_max(int width, int height);
        return rho_offset(width) + (width - 1) * TRIG_ONE + (height - 1) * TRIG_ONE;
    endfunction

    function automatic int rho_bins(int width, int height);
        return (rho_sum_max(width, height) >> RHO_SHIFT) + 1;
    endfunction

    function automatic int bin_index_bits(int width, int height);
        return $clog2(rho_bins(width, height) * THETAS);
    endfunction

endpackage

//--- verilog/hough_ctrl_pkg.sv
package hough_ctrl_pkg;

    //////////////////////////////////////////////////
    // frame controller states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CLEAR,
        SCAN,
        VOTE,
        DRAIN,
        EMIT,
        DONE
    } hough_state_t;

    //////////////////////////////////////////////////
    // accumulator commands
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ACC_IDLE,
        ACC_CLEAR,
        ACC_VOTE,
        ACC_READ
    } acc_op_t;

endpackage

//--- verilog/hough_control.sv
module hough_control
    import hough_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       in_empty,
    input  logic [7:0] in_dout,
    input  logic       last_pixel,
    input  logic       last_theta,
    input  logic       last_bin,
    input  logic       emit_ready,
    output logic       in_rd_en,
    output logic       scan_step,
    output logic       theta_clear,
    output logic       theta_step,
    output logic       sweep_clear,
    output logic       sweep_step,
    output logic       vote_valid,
    output logic       hough_done,
    output acc_op_t    acc_op
);

    // covers the rho register and the read-modify-write of the last vote.
    localparam int DRAIN_CYCLES = 3;

    hough_state_t state;
    hough_state_t next_state;

    logic [1:0] drain_cnt;
    logic       last_read;
    logic       sweep_done;

    //////////////////////////////////////////////////
    // state and bookkeeping registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= CLEAR;
            drain_cnt  <= '0;
            last_read  <= 1'b0;
            sweep_done <= 1'b0;
        end else begin
            state <= next_state;

            if (state == DRAIN) begin
                drain_cnt <= drain_cnt + 2'd1;
            end else begin
                drain_cnt <= '0;
            end

            // raster counters move on before the frame ends, so keep the flag.
            if (in_rd_en) begin
                last_read <= last_pixel;
            end

            if (state == DONE) begin
                sweep_done <= 1'b0;
            end else if (acc_op == ACC_READ && last_bin) begin
                sweep_done <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // next state and command decode
    //////////////////////////////////////////////////

    always_comb begin
        next_state  = state;
        in_rd_en    = 1'b0;
        scan_step   = 1'b0;
        theta_clear = 1'b0;
        theta_step  = 1'b0;
        sweep_clear = 1'b0;
        sweep_step  = 1'b0;
        vote_valid  = 1'b0;
        hough_done  = 1'b0;
        acc_op      = ACC_IDLE;

        case (state)
            CLEAR: begin
                acc_op = ACC_CLEAR;
                if (last_bin) begin
                    sweep_clear = 1'b1;
                    next_state  = SCAN;
                end else begin
                    sweep_step = 1'b1;
                end
            end

            SCAN: begin
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    if (in_dout != 8'd0) begin
                        // position is held until the last angle is issued.
                        next_state = VOTE;
                    end else begin
                        scan_step = 1'b1;
                        if (last_pixel) begin
                            next_state = EMIT;
                        end
                    end
                end
            end

            VOTE: begin
                acc_op     = ACC_VOTE;
                vote_valid = 1'b1;
                if (last_theta) begin
                    theta_clear = 1'b1;
                    scan_step   = 1'b1;
                    next_state  = DRAIN;
                end else begin
                    theta_step = 1'b1;
                end
            end

            DRAIN: begin
                acc_op = ACC_VOTE;
                if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
                    next_state = last_read ? EMIT : SCAN;
                end
            end

            EMIT: begin
                if (sweep_done) begin
                    // wait for the last word to leave the output register.
                    if (emit_ready) begin
                        next_state = DONE;
                    end
                end else if (emit_ready) begin
                    acc_op = ACC_READ;
                    if (last_bin) begin
                        sweep_clear = 1'b1;
                    end else begin
                        sweep_step = 1'b1;
                    end
                end
            end

            DONE: begin
                hough_done = 1'b1;
                next_state = SCAN;
            end

            default: begin
                next_state = CLEAR;
            end
        endcase
    end

endmodule

//--- verilog/pixel_scan_counter.sv
module pixel_scan_counter
    import hough_geometry_pkg::*;
#(
    parameter  int IMG_WIDTH   = 16,
    parameter  int IMG_HEIGHT  = 16,
    localparam int X_BITS      = coord_bits(IMG_WIDTH),
    localparam int Y_BITS      = coord_bits(IMG_HEIGHT),
    localparam int INDEX_BITS  = bin_index_bits(IMG_WIDTH, IMG_HEIGHT)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  scan_step,
    input  logic                  theta_clear,
    input  logic                  theta_step,
    input  logic                  sweep_clear,
    input  logic                  sweep_step,
    output logic [X_BITS-1:0]     x,
    output logic [Y_BITS-1:0]     y,
    output logic [THETA_BITS-1:0] theta,
    output logic [INDEX_BITS-1:0] sweep_addr,
    output logic                  last_pixel,
    output logic                  last_theta,
    output logic                  last_bin
);

    localparam int BINS = rho_bins(IMG_WIDTH, IMG_HEIGHT) * THETAS;

    logic last_x;
    logic last_y;

    assign last_x     = (x == X_BITS'(IMG_WIDTH - 1));
    assign last_y     = (y == Y_BITS'(IMG_HEIGHT - 1));
    assign last_pixel = last_x && last_y;
    assign last_theta = (theta == THETA_BITS'(THETAS - 1));
    assign last_bin   = (sweep_addr == INDEX_BITS'(BINS - 1));

    // raster position, x first.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x <= '0;
            y <= '0;
        end else if (scan_step) begin
            if (last_x) begin
                x <= '0;
                y <= last_y ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            theta <= '0;
        end else if (theta_clear) begin
            theta <= '0;
        end else if (theta_step) begin
            theta <= theta + 1'b1;
        end
    end

    // bin sweep, used by both the clear pass and the emit pass.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sweep_addr <= '0;
        end else if (sweep_clear) begin
            sweep_addr <= '0;
        end else if (sweep_step) begin
            sweep_addr <= sweep_addr + 1'b1;
        end
    end

endmodule

//--- verilog/rho_calc.sv
module rho_calc
    import hough_geometry_pkg::*;
#(
    parameter  int IMG_WIDTH   = 16,
    parameter  int IMG_HEIGHT  = 16,
    localparam int X_BITS      = coord_bits(IMG_WIDTH),
    localparam int Y_BITS      = coord_bits(IMG_HEIGHT),
    localparam int INDEX_BITS  = bin_index_bits(IMG_WIDTH, IMG_HEIGHT)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [X_BITS-1:0]     x,
    input  logic [Y_BITS-1:0]     y,
    input  logic [THETA_BITS-1:0] theta,
    input  logic                  vote_valid,
    output logic [INDEX_BITS-1:0] rho_index,
    output logic                  rho_valid
);

    // one spare bit for the sign of the partial products.
    localparam int SUM_BITS = $clog2(rho_sum_max(IMG_WIDTH, IMG_HEIGHT) + 1) + 1;
    localparam int RHO_BITS = INDEX_BITS - THETA_BITS;

    logic        [2*TRIG_BITS-1:0] trig_rom [THETAS];
    logic        [2*TRIG_BITS-1:0] trig_entry;
    logic signed [TRIG_BITS-1:0]   cos_t;
    logic signed [TRIG_BITS-1:0]   sin_t;
    logic signed [SUM_BITS-1:0]    x_s;
    logic signed [SUM_BITS-1:0]    y_s;
    logic signed [SUM_BITS-1:0]    rho_sum;
    logic signed [SUM_BITS-1:0]    rho_bin;

    initial begin
        $readmemh(TRIG_FILE, trig_rom);
    end

    assign trig_entry = trig_rom[theta];
    assign cos_t      = $signed(trig_entry[2*TRIG_BITS-1:TRIG_BITS]);
    assign sin_t      = $signed(trig_entry[TRIG_BITS-1:0]);

    assign x_s = $signed({{(SUM_BITS-X_BITS){1'b0}}, x});
    assign y_s = $signed({{(SUM_BITS-Y_BITS){1'b0}}, y});

    // the offset keeps the sum non-negative for every angle.
    assign rho_sum = x_s * cos_t + y_s * sin_t + SUM_BITS'(rho_offset(IMG_WIDTH));
    assign rho_bin = rho_sum >>> RHO_SHIFT;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rho_valid <= 1'b0;
        end else begin
            rho_valid <= vote_valid;
        end
    end

    // THETAS is a power of two, so bin*THETAS+theta is a concatenation.
    always_ff @(posedge clock) begin
        rho_index <= {rho_bin[RHO_BITS-1:0], theta};
    end

endmodule

//--- verilog/vote_accumulator.sv
module vote_accumulator
    import hough_geometry_pkg::*;
    import hough_ctrl_pkg::*;
#(
    parameter  int IMG_WIDTH   = 16,
    parameter  int IMG_HEIGHT  = 16,
    localparam int INDEX_BITS  = bin_index_bits(IMG_WIDTH, IMG_HEIGHT)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  acc_op_t               acc_op,
    input  logic [INDEX_BITS-1:0] sweep_addr,
    input  logic [INDEX_BITS-1:0] rho_index,
    input  logic                  rho_valid,
    input  logic                  out_full,
    output logic                  emit_ready,
    output logic                  out_wr_en,
    output logic [VOTE_BITS-1:0]  out_count,
    output logic [INDEX_BITS-1:0] out_index
);

    localparam int BINS = rho_bins(IMG_WIDTH, IMG_HEIGHT) * THETAS;

    logic [VOTE_BITS-1:0]  bin_ram [BINS];
    logic [VOTE_BITS-1:0]  rd_data;
    logic [INDEX_BITS-1:0] rd_addr;
    logic [INDEX_BITS-1:0] vote_addr;
    logic [INDEX_BITS-1:0] wr_addr;
    logic [VOTE_BITS-1:0]  wr_data;
    logic                  rd_en;
    logic                  wr_en;
    logic                  vote_rd;
    logic                  emit_rd;
    logic                  vote_pend;
    logic                  out_valid;

    assign vote_rd = (acc_op == ACC_VOTE) && rho_valid;
    assign emit_rd = (acc_op == ACC_READ);
    assign rd_en   = vote_rd || emit_rd;
    assign rd_addr = emit_rd ? sweep_addr : rho_index;

    // clear and read-and-clear both write zero at the sweep address.
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = sweep_addr;
        wr_data = '0;
        if (acc_op == ACC_CLEAR || emit_rd) begin
            wr_en = 1'b1;
        end else if (vote_pend) begin
            wr_en   = 1'b1;
            wr_addr = vote_addr;
            wr_data = (rd_data == '1) ? rd_data : rd_data + 1'b1;
        end
    end

    // read-first RAM; rd_data doubles as the output count register.
    always_ff @(posedge clock) begin
        if (wr_en) begin
            bin_ram[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= bin_ram[rd_addr];
        end
        if (vote_rd) begin
            vote_addr <= rho_index;
        end
        if (emit_rd) begin
            out_index <= sweep_addr;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vote_pend <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            vote_pend <= vote_rd;
            if (emit_rd) begin
                out_valid <= 1'b1;
            end else if (out_wr_en) begin
                out_valid <= 1'b0;
            end
        end
    end

    assign out_count  = rd_data;
    assign out_wr_en  = out_valid && !out_full;
    assign emit_ready = !out_valid || !out_full;

endmodule

//--- verilog/hough_transform_top.sv
module hough_transform_top
    import hough_geometry_pkg::*;
    import hough_ctrl_pkg::*;
#(
    parameter  int IMG_WIDTH   = 16,
    parameter  int IMG_HEIGHT  = 16,
    localparam int INDEX_BITS  = bin_index_bits(IMG_WIDTH, IMG_HEIGHT)
) (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  in_rd_en,
    input  logic                  in_empty,
    input  logic [7:0]            in_dout,
    output logic                  out_wr_en,
    input  logic                  out_full,
    output logic [VOTE_BITS-1:0]  out_count,
    output logic [INDEX_BITS-1:0] out_index,
    output logic                  hough_done
);

    localparam int X_BITS = coord_bits(IMG_WIDTH);
    localparam int Y_BITS = coord_bits(IMG_HEIGHT);

    acc_op_t               acc_op;
    logic                  scan_step;
    logic                  theta_clear;
    logic                  theta_step;
    logic                  sweep_clear;
    logic                  sweep_step;
    logic                  vote_valid;
    logic                  last_pixel;
    logic                  last_theta;
    logic                  last_bin;
    logic                  emit_ready;
    logic [X_BITS-1:0]     x;
    logic [Y_BITS-1:0]     y;
    logic [THETA_BITS-1:0] theta;
    logic [INDEX_BITS-1:0] sweep_addr;
    logic [INDEX_BITS-1:0] rho_index;
    logic                  rho_valid;

    hough_control i_control (
        .clock       (clock),
        .reset       (reset),
        .in_empty    (in_empty),
        .in_dout     (in_dout),
        .last_pixel  (last_pixel),
        .last_theta  (last_theta),
        .last_bin    (last_bin),
        .emit_ready  (emit_ready),
        .in_rd_en    (in_rd_en),
        .scan_step   (scan_step),
        .theta_clear (theta_clear),
        .theta_step  (theta_step),
        .sweep_clear (sweep_clear),
        .sweep_step  (sweep_step),
        .vote_valid  (vote_valid),
        .hough_done  (hough_done),
        .acc_op      (acc_op)
    );

    pixel_scan_counter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) i_counter (
        .clock       (clock),
        .reset       (reset),
        .scan_step   (scan_step),
        .theta_clear (theta_clear),
        .theta_step  (theta_step),
        .sweep_clear (sweep_clear),
        .sweep_step  (sweep_step),
        .x           (x),
        .y           (y),
        .theta       (theta),
        .sweep_addr  (sweep_addr),
        .last_pixel  (last_pixel),
        .last_theta  (last_theta),
        .last_bin    (last_bin)
    );

    rho_calc #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) i_rho (
        .clock      (clock),
        .reset      (reset),
        .x          (x),
        .y          (y),
        .theta      (theta),
        .vote_valid (vote_valid),
        .rho_index  (rho_index),
        .rho_valid  (rho_valid)
    );

    vote_accumulator #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) i_accum (
        .clock      (clock),
        .reset      (reset),
        .acc_op     (acc_op),
        .sweep_addr (sweep_addr),
        .rho_index  (rho_index),
        .rho_valid  (rho_valid),
        .out_full   (out_full),
        .emit_ready (emit_ready),
        .out_wr_en  (out_wr_en),
        .out_count  (out_count),
        .out_index  (out_index)
    );

endmodule

//--- testbench/hough_asserts.sv
module hough_asserts (
    input logic clock,
    input logic reset,
    input logic in_rd_en,
    input logic in_empty,
    input logic out_wr_en,
    input logic out_full,
    input logic hough_done
);

    // the input FIFO is only read while it holds a pixel.
    read_not_empty: assert property (
        @(posedge clock) disable iff (reset) in_rd_en |-> !in_empty
    ) else $error("in_rd_en is high while in_empty is high");

    write_not_full: assert property (
        @(posedge clock) disable iff (reset) out_wr_en |-> !out_full
    ) else $error("out_wr_en is high while out_full is high");

    done_one_cycle: assert property (
        @(posedge clock) disable iff (reset) hough_done |=> !hough_done
    ) else $error("hough_done is high for more than one cycle");

    // the frame closes only after the last word has left.
    done_after_words: assert property (
        @(posedge clock) disable iff (reset) hough_done |-> !out_wr_en
    ) else $error("out_wr_en is high in the hough_done cycle");

endmodule

bind hough_transform_top hough_asserts i_asserts (
    .clock      (clock),
    .reset      (reset),
    .in_rd_en   (in_rd_en),
    .in_empty   (in_empty),
    .out_wr_en  (out_wr_en),
    .out_full   (out_full),
    .hough_done (hough_done)
);

//--- testbench/hough_tb.sv
module hough_tb
    import hough_geometry_pkg::*;
();

    localparam int IMG_WIDTH  = 16;
    localparam int IMG_HEIGHT = 16;
    localparam int PIXELS     = IMG_WIDTH * IMG_HEIGHT;
    // bound on the shifted sum when every trig term is at its largest.
    localparam int RHO_BINS   =
        (((2 * (IMG_WIDTH - 1) + IMG_HEIGHT - 1) << TRIG_FRAC) >> RHO_SHIFT) + 1;
    localparam int BINS       = RHO_BINS * THETAS;
    localparam int INDEX_BITS = $clog2(BINS);
    localparam int TIMEOUT    = 20000;
    localparam int TESTS      = 5;

    logic                  clock;
    logic                  reset;
    logic                  in_rd_en;
    logic                  in_empty;
    logic [7:0]            in_dout;
    logic                  out_wr_en;
    logic                  out_full;
    logic [VOTE_BITS-1:0]  out_count;
    logic [INDEX_BITS-1:0] out_index;
    logic                  hough_done;

    logic [15:0]       trig_words [THETAS];
    logic signed [7:0] cos_tab [THETAS];
    logic signed [7:0] sin_tab [THETAS];
    logic [7:0]        frame [PIXELS];
    logic [7:0]        in_q [$];
    int                out_counts [$];
    int                out_indices [$];
    int                expected [BINS];

    int done_count;
    int words_at_done;
    int frames_run;
    int gap_pct;
    int full_pct;
    int errors;
    int tests_run;
    int tests_failed;
    bit timed_out;
    bit done_prev;

    hough_transform_top #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) i_hough_transform_top (
        .clock      (clock),
        .reset      (reset),
        .in_rd_en   (in_rd_en),
        .in_empty   (in_empty),
        .in_dout    (in_dout),
        .out_wr_en  (out_wr_en),
        .out_full   (out_full),
        .out_count  (out_count),
        .out_index  (out_index),
        .hough_done (hough_done)
    );

    always begin
        #5 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // FIFO models
    //////////////////////////////////////////////////

    // show-ahead input FIFO pops on the rising edge.
    always @(posedge clock) begin
        if (in_rd_en && in_q.size() > 0) begin
            void'(in_q.pop_front());
        end
    end

    always @(negedge clock) begin
        if (reset || in_q.size() == 0 || $urandom_range(99) < gap_pct) begin
            in_empty <= 1'b1;
            in_dout  <= '0;
        end else begin
            in_empty <= 1'b0;
            in_dout  <= in_q[0];
        end
        out_full <= ($urandom_range(99) < full_pct);
    end

    // output sink and strobe rules.
    always @(posedge clock) begin
        if (!reset) begin
            check_value("in_rd_en and in_empty", 0, in_rd_en && in_empty);
            check_value("out_wr_en and out_full", 0, out_wr_en && out_full);
            check_value("hough_done held", 0, hough_done && done_prev);
            if (out_wr_en) begin
                out_counts.push_back(out_count);
                out_indices.push_back(out_index);
            end
            if (hough_done) begin
                done_count++;
                words_at_done = out_counts.size();
            end
        end
        done_prev = hough_done;
    end

    //////////////////////////////////////////////////
    // checks and reference model
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            $display("[ERROR] time %0t %s expected %0d actual %0d", $time, name, exp_val,
                     act_val);
            errors++;
        end
    endtask

    function automatic int rho_bin_of(int x, int y, int t);
        int sum;
        sum = x * cos_tab[t] + y * sin_tab[t] + (IMG_WIDTH - 1) * (1 << TRIG_FRAC);
        return sum >>> RHO_SHIFT;
    endfunction

    task automatic build_model();
        int idx;
        for (int b = 0; b < BINS; b++) begin
            expected[b] = 0;
        end
        for (int p = 0; p < PIXELS; p++) begin
            if (frame[p] != 0) begin
                for (int t = 0; t < THETAS; t++) begin
                    idx = rho_bin_of(p % IMG_WIDTH, p / IMG_WIDTH, t) * THETAS + t;
                    if (expected[idx] < 255) begin
                        expected[idx]++;
                    end
                end
            end
        end
    endtask

    function automatic int count_outputs(int value);
        int n;
        n = 0;
        foreach (out_counts[i]) begin
            if (out_counts[i] == value) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int total_votes();
        int n;
        n = 0;
        foreach (out_counts[i]) begin
            n += out_counts[i];
        end
        return n;
    endfunction

    task automatic fill_frame(input int edge_pct);
        for (int p = 0; p < PIXELS; p++) begin
            if ($urandom_range(99) < edge_pct) begin
                frame[p] = 8'($urandom_range(255, 1));
            end else begin
                frame[p] = '0;
            end
        end
    endtask

    // feeds one frame and compares every emitted bin.
    task automatic run_frame();
        int start_done;
        int start_errors;
        int cycles;
        start_done   = done_count;
        start_errors = errors;
        build_model();
        out_counts.delete();
        out_indices.delete();
        for (int p = 0; p < PIXELS; p++) begin
            in_q.push_back(frame[p]);
        end
        frames_run++;
        cycles = 0;
        while (done_count == start_done && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (done_count == start_done) begin
            $display("timeout, hough_done did not arrive within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
            errors++;
        end else begin
            // one more cycle so that a second pulse would be counted.
            @(negedge clock);
            check_value("hough_done pulses", 1, done_count - start_done);
            check_value("words before hough_done", BINS, words_at_done);
            check_value("pixels left in input FIFO", 0, in_q.size());
            check_value("output word count", BINS, out_counts.size());
            for (int i = 0; i < out_counts.size() && i < BINS; i++) begin
                if (errors - start_errors < 20) begin
                    check_value($sformatf("out_index[%0d]", i), i, out_indices[i]);
                    check_value($sformatf("out_count[%0d]", i), expected[i], out_counts[i]);
                end
            end
        end
    endtask

    task automatic run_test(input int n);
        int    start_errors;
        string name;
        start_errors = errors;
        case (n)
            1: begin
                name = "all-zero frame";
                fill_frame(0);
                run_frame();
            end
            2: begin
                name = "single edge pixel";
                fill_frame(0);
                frame[$urandom_range(PIXELS - 1)] = 8'($urandom_range(255, 1));
                run_frame();
                check_value("bins holding one vote", THETAS, count_outputs(1));
            end
            3: begin
                name = "two random frames";
                fill_frame(30);
                run_frame();
                if (!timed_out) begin
                    fill_frame(30);
                    run_frame();
                end
            end
            4: begin
                name = "all edge pixels";
                fill_frame(100);
                run_frame();
                // a two-pixel strip of a 16x16 frame holds far fewer than 255 pixels.
                check_value("sum of out_count", PIXELS * THETAS, total_votes());
            end
            default: begin
                name = "random gaps and back-pressure";
                gap_pct  = 30;
                full_pct = 40;
                fill_frame(30);
                run_frame();
                gap_pct  = 0;
                full_pct = 0;
            end
        endcase
        tests_run++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", n, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", n, name, errors - start_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'ha535_ff56));
        clock         = 1'b0;
        reset         = 1'b1;
        in_empty      = 1'b1;
        in_dout       = '0;
        out_full      = 1'b0;
        gap_pct       = 0;
        full_pct      = 0;
        done_count    = 0;
        words_at_done = 0;
        frames_run    = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;
        done_prev     = 1'b0;

        $readmemh(TRIG_FILE, trig_words);
        for (int t = 0; t < THETAS; t++) begin
            cos_tab[t] = trig_words[t][15:8];
            sin_tab[t] = trig_words[t][7:0];
        end

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int n = 1; n <= TESTS && !timed_out; n++) begin
            run_test(n);
        end
        if (!timed_out) begin
            check_value("hough_done pulses in run", frames_run, done_count);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/trig_table.hex
// each line holds the cos byte and then the sin byte of one angle.
// both are signed and scaled by 64, angle t is pi*t/16.
4000
3F0C
3B18
3524
2D2D
2435
183B
0C3F
0040
F43F
E83B
DC35
D32D
CB24
C518
C10C

//--- filelist.f
verilog/hough_geometry_pkg.sv
verilog/hough_ctrl_pkg.sv
verilog/hough_control.sv
verilog/pixel_scan_counter.sv
verilog/rho_calc.sv
verilog/vote_accumulator.sv
verilog/hough_transform_top.sv
testbench/hough_asserts.sv
testbench/hough_tb.sv

//--- Bender.yml
package:
  name: hough_transform

sources:
  - files:
      - verilog/hough_geometry_pkg.sv
      - verilog/hough_ctrl_pkg.sv
      - verilog/hough_control.sv
      - verilog/pixel_scan_counter.sv
      - verilog/rho_calc.sv
      - verilog/vote_accumulator.sv
      - verilog/hough_transform_top.sv
  - target: test
    files:
      - testbench/hough_asserts.sv
      - testbench/hough_tb.sv
